/* logic/r5p_alu.sv */
// combinational RV32I integer unit; clk and reset are not used, no word forms or M extension
`timescale 1ns/100ps
`default_nettype none

module r5p_alu import r5p_pkg::*, riscv_isa_pkg::*; #(
  bit cfg_lom = 1'b0  // dedicated logical operand mux
) (
  input  logic  clk,    // unused, no pipeline stage
  input  logic  reset,  // unused
  input  ctl_t  ctl,
  input  data_t pc,
  input  data_t rs1,
  input  data_t rs2,
  output data_t rd,
  output sum_t  sum     // includes sign/borrow bit
);

  fn3_alu_t        f3;
  data_t           mux_op1;  // adder operands before extension
  data_t           mux_op2;
  sum_t            add_op1;  // extended by one bit
  sum_t            add_op2;
  logic            add_inv;  // subtract
  logic            add_sgn;  // signed extension
  data_t           log_op1;
  data_t           log_op2;
  logic [xlog-1:0] shf_sam;  // shift amount
  data_t           shf_tmp;  // operand, reversed for left shift
  data_t           shf_val;

  // one extra bit, sign or zero
  function automatic sum_t extend(data_t val, logic sgn);
    return {sgn & val[xlen-1], val};
  endfunction

  function automatic data_t bitrev(data_t val);
    data_t r;
    for (int unsigned i = 0; i < xlen; i++) begin
      r[i] = val[xlen-1-i];
    end
    return r;
  endfunction

  assign f3 = fn3_alu_t'(ctl.f3);

  ////////////////////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mux_op1 = rs1;
    mux_op2 = rs2;                    // OP, BRANCH
    case (ctl.opc)
      OP_IMM, JALR, LOAD: mux_op2 = ctl.imm.i;
      STORE:              mux_op2 = ctl.imm.s;
      AUIPC: begin
        mux_op1 = pc;
        mux_op2 = ctl.imm.u;
      end
      JAL: begin
        mux_op1 = pc;
        mux_op2 = ctl.imm.j;
      end
      LUI: begin
        mux_op1 = '0;                 // sum equals imm.u
        mux_op2 = ctl.imm.u;
      end
      default: ;
    endcase
  end

  always_comb begin
    add_inv = 1'b0;
    add_sgn = 1'b0;
    case (ctl.opc)
      OP, OP_IMM: begin
        case (f3)
          ADD:  add_inv = (ctl.opc == OP) & ctl.f7_5;  // no subi
          SLT: begin
            add_inv = 1'b1;
            add_sgn = 1'b1;
          end
          SLTU: add_inv = 1'b1;
          default: ;
        endcase
      end
      BRANCH: begin
        add_inv = 1'b1;               // compare by rs1-rs2
        add_sgn = ~ctl.f3[1];         // bltu/bgeu unsigned
      end
      default: ;
    endcase
  end

  assign add_op1 = extend(mux_op1, add_sgn);
  assign add_op2 = extend(mux_op2, add_sgn);
  assign sum     = add_op1 + (add_inv ? ~add_op2 : add_op2) + sum_t'(add_inv);

  ////////////////////////////////////////////////////////////////////////////
  // logical operands and shifter
  ////////////////////////////////////////////////////////////////////////////

  if (cfg_lom) begin : g_lom
    always_comb begin
      log_op1 = rs1;
      log_op2 = (ctl.opc == OP_IMM) ? ctl.imm.i : rs2;
    end
  end else begin : g_shared
    assign log_op1 = rs1;
    assign log_op2 = mux_op2;         // before inversion
  end

  assign shf_sam = log_op2[xlog-1:0];                    // shamt shares op 2
  assign shf_tmp = (f3 == SL) ? bitrev(rs1) : rs1;

  always_comb begin
    if (f3 == SR && ctl.f7_5) begin
      shf_val = $signed(shf_tmp) >>> shf_sam;             // sra
    end else begin
      shf_val = shf_tmp >> shf_sam;
    end
  end

  // result mux
  always_comb begin
    rd = sum[xlen-1:0];               // auipc and address forms
    if (ctl.opc == OP || ctl.opc == OP_IMM) begin
      case (f3)
        SLT, SLTU: rd = data_t'(sum[xlen]);
        AND:       rd = log_op1 & log_op2;
        OR:        rd = log_op1 | log_op2;
        XOR:       rd = log_op1 ^ log_op2;
        SR:        rd = shf_val;
        SL:        rd = bitrev(shf_val);
        default:   rd = sum[xlen-1:0];
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/r5p_bru.sv */
// branch compare relies on the ALU subtracting rs2 from rs1; no target alignment check
`timescale 1ns/100ps
`default_nettype none

module r5p_bru import r5p_pkg::*, riscv_isa_pkg::*; (
  input  ctl_t  ctl,
  input  data_t pc,
  input  sum_t  sum,     // rs1-rs2 for branches, rs1+imm for jalr
  output logic  taken,
  output data_t target,
  output data_t link     // return address
);

  logic eq;
  logic lt;
  logic cond;

  assign eq = (sum[xlen-1:0] == '0);  // zero difference
  assign lt = sum[xlen];              // borrow, signedness set in ALU

  always_comb begin
    case (fn3_bru_t'(ctl.f3))
      BEQ:        cond = eq;
      BNE:        cond = ~eq;
      BLT, BLTU:  cond = lt;
      BGE, BGEU:  cond = ~lt;
      default:    cond = 1'b0;      // reserved
    endcase
  end

  always_comb begin
    case (ctl.opc)
      BRANCH:    taken = cond;
      JAL, JALR: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  always_comb begin
    case (ctl.opc)
      JALR:    target = {sum[xlen-1:1], 1'b0};  // bit 0 cleared
      JAL:     target = pc + ctl.imm.j;
      default: target = pc + ctl.imm.b;
    endcase
  end

  assign link = pc + data_t'(4);

endmodule

`default_nettype wire

/* logic/r5p_ctl.sv */
// funct7 is not checked, so reserved OP/OP_IMM encodings run as their base operation
`timescale 1ns/100ps
`default_nettype none

module r5p_ctl import r5p_pkg::*, riscv_isa_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,  // one instruction per strobe
  input  insn_t    insn,
  // datapath results
  input  data_t    alu_rd,
  input  data_t    link,      // pc+4
  input  logic     taken,
  input  data_t    target,
  input  mem_req_t mem,
  // decode and result
  output ctl_t     ctl,
  output logic     out_valid,
  output ex_res_t  res
);

  insn_fld_t fld;      // fixed field positions
  logic      legal;    // funct3 fits the opcode
  data_t     rd_val;
  logic      rd_wr;    // opcode writes rd
  ex_res_t   res_nxt;

  // drop every enable, data fields pass through
  function automatic ex_res_t mask_en(ex_res_t r);
    ex_res_t m;
    m                = r;
    m.rd_we          = 1'b0;
    m.taken          = 1'b0;
    m.mem.req        = 1'b0;
    m.mem.we         = 1'b0;
    m.mem.misaligned = 1'b0;
    m.illegal        = 1'b0;
    return m;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  assign fld = insn_fld_t'(insn);

  always_comb begin
    case (fld.opcode)
      LOAD:   legal = fld.funct3 inside {BYTE, HALF, WORD, BYTEU, HALFU};
      STORE:  legal = fld.funct3 inside {BYTE, HALF, WORD};
      BRANCH: legal = fld.funct3 inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
      JALR:   legal = (fld.funct3 == 3'b000);
      JAL, OP, OP_IMM, AUIPC, LUI: legal = 1'b1;
      default: legal = 1'b0;  // unknown opcode
    endcase
  end

  always_comb begin
    ctl.opc     = fld.opcode;
    ctl.f3      = fld.funct3;
    ctl.f7_5    = fld.funct7[5];
    // immediates, sign bit is always insn[31]
    ctl.imm.i   = {{20{insn[31]}}, insn[31:20]};
    ctl.imm.s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    ctl.imm.b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    ctl.imm.u   = {insn[31:12], 12'h000};
    ctl.imm.j   = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    ctl.illegal = ~legal;
  end

  ////////////////////////////////////////////////////////////////////////////
  // result select and output register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctl.opc)
      OP, OP_IMM, AUIPC: begin
        rd_val = alu_rd;
        rd_wr  = 1'b1;
      end
      JAL, JALR: begin
        rd_val = link;   // return address
        rd_wr  = 1'b1;
      end
      LUI: begin
        rd_val = ctl.imm.u;
        rd_wr  = 1'b1;
      end
      default: begin     // loads, stores, branches
        rd_val = alu_rd;
        rd_wr  = 1'b0;
      end
    endcase
  end

  // illegal instruction writes and requests nothing
  always_comb begin
    res_nxt         = '0;
    res_nxt.rd      = rd_val;
    res_nxt.rd_we   = rd_wr & (fld.rd != 5'd0) & ~ctl.illegal;  // x0 stays zero
    res_nxt.taken   = taken & ~ctl.illegal;
    res_nxt.target  = target;
    res_nxt.mem     = mem;
    res_nxt.mem.req = mem.req & ~ctl.illegal;
    res_nxt.mem.we  = mem.we & ~ctl.illegal;
    res_nxt.illegal = ctl.illegal;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      res       <= mask_en(res);
    end else begin
      out_valid <= in_valid;
      res       <= in_valid ? res_nxt : mask_en(res);  // idle keeps data
    end
  end

endmodule

`default_nettype wire

/* logic/r5p_exec.sv */
// one result per in_valid strobe one cycle later; no back-pressure, results must be taken at once
`timescale 1ns/100ps
`default_nettype none

module r5p_exec import r5p_pkg::*, riscv_isa_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    in_valid,
  input  insn_t   insn,
  input  data_t   pc,
  input  data_t   rs1,
  input  data_t   rs2,
  output logic    out_valid,
  output ex_res_t res
);

  ctl_t     ctl;     // decode to datapath
  data_t    alu_rd;
  sum_t     sum;     // shared by branch and address paths
  logic     taken;
  data_t    target;
  data_t    link;
  mem_req_t mem;

  r5p_ctl u_ctl (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .insn      (insn),
    .alu_rd    (alu_rd),
    .link      (link),
    .taken     (taken),
    .target    (target),
    .mem       (mem),
    .ctl       (ctl),
    .out_valid (out_valid),
    .res       (res)
  );

  r5p_alu #(
    .cfg_lom (1'b0)  // logic operands via adder mux
  ) u_alu (
    .clk   (clk),
    .reset (reset),
    .ctl   (ctl),
    .pc    (pc),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (alu_rd),
    .sum   (sum)
  );

  r5p_bru u_bru (
    .ctl    (ctl),
    .pc     (pc),
    .sum    (sum),
    .taken  (taken),
    .target (target),
    .link   (link)
  );

  r5p_lsa u_lsa (
    .ctl (ctl),
    .sum (sum),
    .rs2 (rs2),
    .mem (mem)
  );

endmodule

`default_nettype wire

/* logic/r5p_lsa.sv */
// 32-bit data bus with four byte lanes; misaligned accesses are dropped, not split
`timescale 1ns/100ps
`default_nettype none

module r5p_lsa import r5p_pkg::*, riscv_isa_pkg::*; (
  input  ctl_t     ctl,
  input  sum_t     sum,   // rs1+imm from the ALU
  input  data_t    rs2,
  output mem_req_t mem
);

  logic       acc;   // load or store
  logic [1:0] ofs;   // byte offset in word
  be_t        be;
  data_t      wdata;
  logic       mis;

  assign acc = (ctl.opc == LOAD) || (ctl.opc == STORE);
  assign ofs = sum[1:0];

  always_comb begin
    case (fn3_ldst_t'(ctl.f3))
      BYTE, BYTEU: begin
        be    = be_t'(4'b0001) << ofs;
        wdata = {4{rs2[7:0]}};
        mis   = 1'b0;
      end
      HALF, HALFU: begin
        be    = be_t'(4'b0011) << ofs;
        wdata = {2{rs2[15:0]}};
        mis   = ofs[0];             // odd address
      end
      WORD: begin
        be    = 4'b1111;
        wdata = rs2;
        mis   = |ofs;
      end
      default: begin                // reserved size
        be    = '0;
        wdata = rs2;
        mis   = 1'b0;
      end
    endcase
  end

  always_comb begin
    mem.req        = acc & ~mis;
    mem.we         = (ctl.opc == STORE) & ~mis;
    mem.addr       = sum[xlen-1:0];  // reported even when dropped
    mem.be         = (acc & ~mis) ? be : '0;
    mem.wdata      = wdata;
    mem.misaligned = acc & mis;
  end

endmodule

`default_nettype wire

/* logic/r5p_pkg.sv */
// fixed to RV32 with a 32-bit data bus; byte enables assume four byte lanes
`default_nettype none

package r5p_pkg;

  import riscv_isa_pkg::*;

  localparam int unsigned xlen = 32;
  localparam int unsigned xlog = 5;  // shift amount width

  typedef logic [xlen-1:0]   data_t;  // register and address word
  typedef logic [xlen-0:0]   sum_t;   // adder out with sign/borrow bit
  typedef logic [xlen/8-1:0] be_t;    // one bit per byte lane

  // decoded instruction
  typedef struct packed {
    opc_t       opc;
    logic [2:0] f3;       // funct3, read through the matching enum
    logic       f7_5;     // insn[30], sub/sra select
    imm_t       imm;
    logic       illegal;  // unknown opcode or bad funct3
  } ctl_t;

  // memory request, load data return is outside
  typedef struct packed {
    logic  req;         // valid aligned access
    logic  we;          // store
    data_t addr;
    be_t   be;
    data_t wdata;       // rs2 replicated over lanes
    logic  misaligned;  // access dropped, addr kept
  } mem_req_t;

  // registered execute result
  typedef struct packed {
    data_t    rd;
    logic     rd_we;
    logic     taken;   // jump or taken branch
    data_t    target;
    mem_req_t mem;
    logic     illegal;
  } ex_res_t;

endpackage

`default_nettype wire

/* logic/riscv_isa_pkg.sv */
// RV32I base encodings only; no compressed, M, CSR or 64-bit word forms are listed
`default_nettype none

package riscv_isa_pkg;

  typedef logic [31:0] insn_t;  // raw instruction word

  ////////////////////////////////////////////////////////////////////////////
  // opcodes and function codes
  ////////////////////////////////////////////////////////////////////////////

  // major opcode, insn[6:0]
  typedef enum logic [6:0] {
    LOAD   = 7'b00_000_11,
    STORE  = 7'b01_000_11,
    BRANCH = 7'b11_000_11,
    JALR   = 7'b11_001_11,
    JAL    = 7'b11_011_11,
    OP_IMM = 7'b00_100_11,
    OP     = 7'b01_100_11,
    AUIPC  = 7'b00_101_11,
    LUI    = 7'b01_101_11
  } opc_t;

  // arithmetic/logic funct3
  typedef enum logic [2:0] {
    ADD  = 3'b000,  // also sub, by funct7[5] in R-type
    SL   = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SR   = 3'b101,  // srl/sra by funct7[5]
    OR   = 3'b110,
    AND  = 3'b111
  } fn3_alu_t;

  // branch funct3, 010 and 011 reserved
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } fn3_bru_t;

  // load/store size, unsigned forms are loads only
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HALF  = 3'b001,
    WORD  = 3'b010,
    BYTEU = 3'b100,
    HALFU = 3'b101
  } fn3_ldst_t;

  ////////////////////////////////////////////////////////////////////////////
  // field and immediate layouts
  ////////////////////////////////////////////////////////////////////////////

  // R-type view, positions hold for every format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opc_t       opcode;
  } insn_fld_t;

  // all immediate formats, sign extended
  typedef struct packed {
    logic [31:0] i;  // I-type, loads, jalr, op-imm
    logic [31:0] s;  // S-type, stores
    logic [31:0] b;  // B-type, branch offset
    logic [31:0] u;  // U-type, low 12 bits zero
    logic [31:0] j;  // J-type, jal offset
  } imm_t;

endpackage

`default_nettype wire

/* run_verilator.sh */
#!/bin/sh
# build with Verilator from the project root, then run and search the output

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module r5p_exec_tb -o r5p_exec_sim \
  && ./obj_dir/r5p_exec_sim | tee /dev/stderr | grep -q "Simulation passed" \
  && echo "run_verilator: PASS" \
  || { echo "run_verilator: FAIL"; exit 1; }

/* sim.f */
logic/riscv_isa_pkg.sv
logic/r5p_pkg.sv
logic/r5p_alu.sv
logic/r5p_bru.sv
logic/r5p_lsa.sv
logic/r5p_ctl.sv
logic/r5p_exec.sv
verification/r5p_exec_sva.sv
verification/r5p_exec_tb.sv

/* verification/r5p_exec_sva.sv */
// bound into r5p_ctl; all checks are disabled while reset is high
`timescale 1ns/100ps
`default_nettype none

module r5p_exec_sva import r5p_pkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    in_valid,
  input logic    out_valid,
  input ex_res_t res
);

  // one result per strobe, one cycle later
  a_valid_next: assert property (@(posedge clk) disable iff (reset)
    in_valid |=> out_valid)
    else $error("out_valid missing one cycle after in_valid");

  // idle output carries no enable
  a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
    !out_valid |-> !(res.rd_we || res.taken || res.mem.req || res.mem.we || res.illegal))
    else $error("enable active while out_valid is low");

  a_req_aligned: assert property (@(posedge clk) disable iff (reset)
    !(res.mem.req && res.mem.misaligned))
    else $error("memory request raised for a misaligned access");

  // illegal insn writes and requests nothing
  a_illegal_mute: assert property (@(posedge clk) disable iff (reset)
    res.illegal |-> (!res.rd_we && !res.mem.req))
    else $error("illegal instruction with rd write or memory request");

endmodule

bind r5p_ctl r5p_exec_sva u_sva (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .res       (res)
);

`default_nettype wire

/* verification/r5p_exec_tb.sv */
// expects to run from the project root; target checked for jumps/branches, mem fields for ld/st
`timescale 1ns/100ps
`default_nettype none

module r5p_exec_tb import r5p_pkg::*, riscv_isa_pkg::*;;

  localparam int result_timeout = 16;  // cycles to wait for out_valid

  // one stimulus line with its expected result
  typedef struct packed {
    insn_t   insn;
    data_t   pc;
    data_t   rs1;
    data_t   rs2;
    ex_res_t exp;
  } vec_t;

  logic    clk;
  logic    reset;
  logic    in_valid;
  insn_t   insn;
  data_t   pc;
  data_t   rs1;
  data_t   rs2;
  logic    out_valid;
  ex_res_t res;

  vec_t vecs[$];      // whole data file
  vec_t expq[$];      // issued and still pending
  int   seed    = 21;
  int   n_data  = 0;
  int   n_be    = 0;
  int   n_flag  = 0;
  int   n_other = 0;  // file, timeout, ordering

  r5p_exec dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .insn      (insn),
    .pc        (pc),
    .rs1       (rs1),
    .rs2       (rs2),
    .out_valid (out_valid),
    .res       (res)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      n_data++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_be(input string name, input be_t got, input be_t exp);
    if (got !== exp) begin
      n_be++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      n_flag++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  // no enable may leak out while idle or in reset
  task automatic check_idle();
    check_flag("idle out_valid", out_valid, 1'b0);
    check_flag("idle rd_we", res.rd_we, 1'b0);
    check_flag("idle taken", res.taken, 1'b0);
    check_flag("idle mem.req", res.mem.req, 1'b0);
    check_flag("idle mem.we", res.mem.we, 1'b0);
    check_flag("idle illegal", res.illegal, 1'b0);
  endtask

  task automatic check_result(input int idx, input vec_t v);
    string      tag;
    logic [6:0] opc;
    logic       is_mem;
    logic       is_cf;   // jump or branch
    tag    = $sformatf("vec%0d ", idx);
    opc    = v.insn[6:0];
    is_mem = (opc == LOAD) || (opc == STORE);
    is_cf  = (opc == BRANCH) || (opc == JAL) || (opc == JALR);
    check_flag({tag, "illegal"}, res.illegal, v.exp.illegal);
    check_flag({tag, "rd_we"}, res.rd_we, v.exp.rd_we);
    check_flag({tag, "taken"}, res.taken, v.exp.taken);
    check_flag({tag, "mem.req"}, res.mem.req, v.exp.mem.req);
    check_flag({tag, "mem.misaligned"}, res.mem.misaligned, v.exp.mem.misaligned);
    check_flag({tag, "mem.we"}, res.mem.we, v.exp.mem.req & (opc == STORE));  // stores only
    if (v.exp.rd_we) check_data({tag, "rd"}, res.rd, v.exp.rd);
    if (is_cf) check_data({tag, "target"}, res.target, v.exp.target);
    if (is_mem) begin
      check_data({tag, "mem.addr"}, res.mem.addr, v.exp.mem.addr);
      check_be({tag, "mem.be"}, res.mem.be, v.exp.mem.be);
      if (opc == STORE) check_data({tag, "mem.wdata"}, res.mem.wdata, v.exp.mem.wdata);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // data file, driver and collector
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [14];
    vec_t        v;
    fd = $fopen("verification/r5p_exec_testdata.txt", "r");
    if (fd == 0) begin
      n_other++;
      $display("test data file could not be opened");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                  f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
      if (n != 14) begin
        n_other++;
        $display("malformed test data line: %s", line);
        continue;
      end
      v                    = '0;
      v.insn               = f[0];
      v.pc                 = f[1];
      v.rs1                = f[2];
      v.rs2                = f[3];
      v.exp.rd             = f[4];
      v.exp.rd_we          = f[5][0];
      v.exp.taken          = f[6][0];
      v.exp.target         = f[7];
      v.exp.mem.addr       = f[8];
      v.exp.mem.be         = be_t'(f[9]);
      v.exp.mem.wdata      = f[10];
      v.exp.mem.req        = f[11][0];
      v.exp.mem.misaligned = f[12][0];
      v.exp.illegal        = f[13][0];
      vecs.push_back(v);
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      n_other++;
      $display("test data file holds no vectors");
    end
  endtask

  // strobes mostly back to back with random idle gaps
  task automatic drive_all();
    int gap;
    foreach (vecs[i]) begin
      gap = $random(seed) & 7;
      if (gap > 2) gap = 0;
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      in_valid <= 1'b1;
      insn     <= vecs[i].insn;
      pc       <= vecs[i].pc;
      rs1      <= vecs[i].rs1;
      rs2      <= vecs[i].rs2;
      expq.push_back(vecs[i]);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // samples at falling edges away from the DUT update
  task automatic collect_all();
    int   wait_cyc;
    vec_t v;
    logic strobed;  // in_valid one falling edge earlier
    strobed = in_valid;
    for (int i = 0; i < vecs.size(); i++) begin
      wait_cyc = 0;
      @(negedge clk);
      while (!out_valid && wait_cyc < result_timeout) begin
        check_flag("out_valid", out_valid, strobed);  // result due one cycle after strobe
        check_idle();
        strobed = in_valid;
        wait_cyc++;
        @(negedge clk);
      end
      if (!out_valid) begin
        n_other++;
        $display("no result arrived for vector %0d within %0d cycles", i, result_timeout);
        return;
      end
      check_flag("out_valid", out_valid, strobed);  // no result without a strobe
      strobed = in_valid;
      if (expq.size() == 0) begin
        n_other++;
        $display("a result arrived with no instruction pending");
        return;
      end
      v = expq.pop_front();
      check_result(i, v);
    end
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
  endtask

  initial begin
    reset    <= 1'b1;
    in_valid <= 1'b0;
    insn     <= '0;
    pc       <= '0;
    rs1      <= '0;
    rs2      <= '0;
    load_vectors();
    repeat (15) begin        // reset held for 16 rising edges
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    reset <= 1'b0;
    fork
      drive_all();
      collect_all();
    join
    $display("errors: data %0d, byte enable %0d, flag %0d, other %0d",
             n_data, n_be, n_flag, n_other);
    if (n_data + n_be + n_flag + n_other == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/r5p_exec_testdata.txt */
# insn pc rs1 rs2 | rd rd_we taken target | addr be wdata req misaligned illegal (all hex)
# target checked for jumps and branches, addr/be for loads and stores, wdata for stores only
003100b3 00001000 7fffffff 00000001 80000000 1 0 0 0 0 0 0 0 0
403100b3 00001000 00000005 00000007 fffffffe 1 0 0 0 0 0 0 0 0
003120b3 00001000 ffffffff 00000001 00000001 1 0 0 0 0 0 0 0 0
003130b3 00001000 ffffffff 00000001 00000000 1 0 0 0 0 0 0 0 0
003140b3 00001000 f0f0f0f0 ff00ff00 0ff00ff0 1 0 0 0 0 0 0 0 0
003160b3 00001000 f0f0f0f0 0f0000ff fff0f0ff 1 0 0 0 0 0 0 0 0
003170b3 00001000 f0f0f0f0 ff00ff00 f000f000 1 0 0 0 0 0 0 0 0
003110b3 00001000 00000001 0000001f 80000000 1 0 0 0 0 0 0 0 0
003150b3 00001000 80000000 00000000 80000000 1 0 0 0 0 0 0 0 0
403150b3 00001000 80000000 0000001f ffffffff 1 0 0 0 0 0 0 0 0
fff10093 00001000 00000000 00000000 ffffffff 1 0 0 0 0 0 0 0 0
fff12093 00001000 80000000 00000000 00000001 1 0 0 0 0 0 0 0 0
40415093 00001000 f0000000 00000000 ff000000 1 0 0 0 0 0 0 0 0
123450b7 00001000 00000000 00000000 12345000 1 0 0 0 0 0 0 0 0
00001097 00001000 00000000 00000000 00002000 1 0 0 0 0 0 0 0 0
008000ef 00001000 00000000 00000000 00001004 1 1 00001008 0 0 0 0 0 0
005100e7 00001000 00002000 00000000 00001004 1 1 00002004 0 0 0 0 0 0
00310863 00001000 00000055 00000055 0 0 1 00001010 0 0 0 0 0 0
00310863 00001000 00000055 00000056 0 0 0 00001010 0 0 0 0 0 0
00311863 00001000 00000001 00000002 0 0 1 00001010 0 0 0 0 0 0
00311863 00001000 00000007 00000007 0 0 0 00001010 0 0 0 0 0 0
00314863 00001000 fffffffe 00000001 0 0 1 00001010 0 0 0 0 0 0
00314863 00001000 00000001 fffffffe 0 0 0 00001010 0 0 0 0 0 0
00315863 00001000 00000005 00000005 0 0 1 00001010 0 0 0 0 0 0
00315863 00001000 80000000 00000000 0 0 0 00001010 0 0 0 0 0 0
00316863 00001000 00000001 fffffffe 0 0 1 00001010 0 0 0 0 0 0
00316863 00001000 fffffffe 00000001 0 0 0 00001010 0 0 0 0 0 0
00317863 00001000 80000000 00000000 0 0 1 00001010 0 0 0 0 0 0
00317863 00001000 00000000 00000001 0 0 0 00001010 0 0 0 0 0 0
00812083 00001000 00002000 00000000 0 0 0 0 00002008 f 0 1 0 0
00314083 00001000 00002000 00000000 0 0 0 0 00002003 8 0 1 0 0
00111083 00001000 00002000 00000000 0 0 0 0 00002001 0 0 0 1 0
003100a3 00001000 00002000 000000ab 0 0 0 0 00002001 2 abababab 1 0 0
00311123 00001000 00002000 1234cdef 0 0 0 0 00002002 c cdefcdef 1 0 0
fe312e23 00001000 00002000 deadbeef 0 0 0 0 00001ffc f deadbeef 1 0 0
00312323 00001000 00002000 11223344 0 0 0 0 00002006 0 11223344 0 1 0
000000ff 00001000 00000000 00000000 0 0 0 0 0 0 0 0 0 1
00310033 00001000 00000001 00000002 0 0 0 0 0 0 0 0 0 0
